// File: rtl/strand_config.svh
`ifndef STRAND_CONFIG_SVH
`define STRAND_CONFIG_SVH

// Number of hardware strands sharing the pipeline
`define STRAND_COUNT 4

// Issued to decode whenever no strand wins arbitration
`define NOP_INSTRUCTION 32'h0000_0000

// Cycles after a long-latency issue in which a short-latency issue
// would land on the same writeback slot
`define WRITEBACK_GAP 2

`endif

// File: rtl/strand_pkg.sv
`default_nettype none

package strand_pkg;

	typedef logic [1:0] strand_idx_t;

	// Register format: arithmetic and long-latency operations
	typedef struct packed {
		logic fmt;
		logic [5:0] opcode;
		logic [4:0] dest;
		logic [4:0] src_a;
		logic [4:0] src_b;
		logic [9:0] pad;
	} reg_format_t;

	// Memory format: loads and stores, always short latency at this stage
	typedef struct packed {
		logic fmt;
		logic load;
		logic [4:0] base;
		logic [4:0] data;
		logic [19:0] offset;
	} mem_format_t;

	// Bit 31 is the format bit in both views
	typedef union packed {
		reg_format_t r;
		mem_format_t m;
	} instruction_t;

endpackage

`default_nettype wire

// File: rtl/strand_issue_if.sv
`default_nettype none
`timescale 1ns/1ps

interface strand_issue_if;
	import strand_pkg::*;

	// Strand holds an instruction and is not suspended
	logic request;
	// Consumes the buffered instruction at the next edge
	logic grant;
	instruction_t instruction;
	logic [31:0] pc;

	modport fsm (
		output request,
		output instruction,
		output pc,
		input grant
	);

	modport stage (
		input request,
		input instruction,
		input pc,
		output grant
	);

endinterface

`default_nettype wire

// File: rtl/strand_fsm.sv
`default_nettype none
`timescale 1ns/1ps

module strand_fsm
(
	input logic clk,
	input logic reset_i,
	input logic instruction_valid_i,
	input strand_pkg::instruction_t instruction_i,
	input logic [31:0] pc_i,
	input logic suspend_i,
	input logic resume_i,
	input logic rollback_i,
	input logic retry_i,
	output logic fetch_req_o,
	strand_issue_if.fsm issue
);
	import strand_pkg::*;

	logic buffer_valid;
	logic suspended;
	instruction_t buffered_instruction;
	logic [31:0] buffered_pc;
	instruction_t last_instruction;
	logic [31:0] last_pc;
	logic load;

	// Fetch only into an empty buffer of a running strand
	assign fetch_req_o = !buffer_valid && !suspended;
	assign load = instruction_valid_i && fetch_req_o;

	assign issue.request = buffer_valid && !suspended;
	assign issue.instruction = buffered_instruction;
	assign issue.pc = buffered_pc;

	// Buffer occupancy, rollback first, then retry, grant and load
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			buffer_valid <= 1'b0;
		end
		else if (rollback_i)
		begin
			buffer_valid <= 1'b0;
		end
		else if (retry_i)
		begin
			buffer_valid <= 1'b1;
		end
		else if (issue.grant)
		begin
			buffer_valid <= 1'b0;
		end
		else if (load)
		begin
			buffer_valid <= 1'b1;
		end
	end

	// A rollback also wakes a strand that was waiting
	always_ff @(posedge clk)
	begin
		if (reset_i)
			suspended <= 1'b0;
		else if (rollback_i)
			suspended <= 1'b0;
		else if (suspend_i)
			suspended <= 1'b1;
		else if (resume_i)
			suspended <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (rollback_i)
		begin
			// Buffer contents are dropped, nothing to update
		end
		else if (retry_i)
		begin
			buffered_instruction <= last_instruction;
			buffered_pc <= last_pc;
		end
		else if (issue.grant)
		begin
			last_instruction <= buffered_instruction;
			last_pc <= buffered_pc;
		end
		else if (load)
		begin
			buffered_instruction <= instruction_i;
			buffered_pc <= pc_i;
		end
	end

endmodule

`default_nettype wire

// File: rtl/issue_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

`include "strand_config.svh"

module issue_arbiter
(
	input logic clk,
	input logic reset_i,
	input logic [`STRAND_COUNT-1:0] request_i,
	output logic [`STRAND_COUNT-1:0] grant_o
);
	localparam int N = `STRAND_COUNT;
	localparam int IDX_W = $clog2(N);

	logic [IDX_W-1:0] pointer;
	logic [2*N-1:0] doubled;
	logic [N-1:0] rotated;
	logic [IDX_W-1:0] offset;
	logic [IDX_W-1:0] winner;
	logic found;

	// Rotate requests so the pointer strand sits at bit 0
	always_comb
	begin
		doubled = {request_i, request_i} >> pointer;
		rotated = doubled[N-1:0];
		found = 1'b0;
		offset = '0;
		for (int i = N - 1; i >= 0; i--)
		begin
			if (rotated[i])
			begin
				found = 1'b1;
				offset = IDX_W'(i);
			end
		end
		// Index arithmetic wraps naturally for a power-of-two count
		winner = pointer + offset;
		grant_o = found ? (N'(1) << winner) : '0;
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
			pointer <= '0;
		else if (found)
			pointer <= winner + IDX_W'(1);
	end

endmodule

`default_nettype wire

// File: rtl/execute_hazard_detect.sv
`default_nettype none
`timescale 1ns/1ps

`include "strand_config.svh"

module execute_hazard_detect
(
	input logic clk,
	input logic reset_i,
	input strand_pkg::instruction_t instruction_i [`STRAND_COUNT],
	input logic [`STRAND_COUNT-1:0] grant_i,
	output logic [`STRAND_COUNT-1:0] hazard_o
);
	import strand_pkg::*;

	localparam int N = `STRAND_COUNT;
	localparam int GAP = `WRITEBACK_GAP;

	logic [N-1:0] long_candidate;
	logic granted_long;
	logic [GAP-1:0] history;

	// Long latency is a register-format word with the top opcode bit set
	always_comb
	begin
		for (int i = 0; i < N; i++)
		begin
			long_candidate[i] = instruction_i[i].r.fmt && instruction_i[i].r.opcode[5];
		end
	end

	assign granted_long = |(grant_i & long_candidate);

	// Bit 0 is the most recent cycle, the top bit is the writeback slot
	always_ff @(posedge clk)
	begin
		if (reset_i)
			history <= '0;
		else
			history <= (history << 1) | GAP'(granted_long);
	end

	// Only short instructions are held back, another long one lines up behind
	always_comb
	begin
		if (history[GAP-1])
			hazard_o = ~long_candidate;
		else
			hazard_o = '0;
	end

endmodule

`default_nettype wire

// File: rtl/strand_select_stage.sv
`default_nettype none
`timescale 1ns/1ps

`include "strand_config.svh"

module strand_select_stage
(
	input logic clk,
	input logic reset_i,
	input logic [`STRAND_COUNT-1:0] strand_enable_i,
	input logic [31:0] if_instruction_i [`STRAND_COUNT],
	input logic [`STRAND_COUNT-1:0] if_instruction_valid_i,
	input logic [31:0] if_pc_i [`STRAND_COUNT],
	input logic [`STRAND_COUNT-1:0] suspend_strand_i,
	input logic [`STRAND_COUNT-1:0] resume_strand_i,
	input logic [`STRAND_COUNT-1:0] rollback_strand_i,
	input logic [`STRAND_COUNT-1:0] retry_strand_i,
	output logic [`STRAND_COUNT-1:0] ss_instruction_req_o,
	output logic [31:0] ss_instruction_o,
	output logic [31:0] ss_pc_o,
	output strand_pkg::strand_idx_t ss_strand_o
);
	import strand_pkg::*;

	localparam int N = `STRAND_COUNT;

	logic [N-1:0] strand_request;
	logic [N-1:0] arb_request;
	logic [N-1:0] grant;
	logic [N-1:0] hazard;
	instruction_t candidate_instruction [N];
	logic [31:0] candidate_pc [N];
	strand_idx_t grant_idx;

	for (genvar g = 0; g < N; g++)
	begin : g_strand
		strand_issue_if issue ();

		strand_fsm u_fsm (
			.clk(clk),
			.reset_i(reset_i),
			.instruction_valid_i(if_instruction_valid_i[g]),
			.instruction_i(if_instruction_i[g]),
			.pc_i(if_pc_i[g]),
			.suspend_i(suspend_strand_i[g]),
			.resume_i(resume_strand_i[g]),
			.rollback_i(rollback_strand_i[g]),
			.retry_i(retry_strand_i[g]),
			.fetch_req_o(ss_instruction_req_o[g]),
			.issue(issue.fsm)
		);

		assign strand_request[g] = issue.request;
		assign candidate_instruction[g] = issue.instruction;
		assign candidate_pc[g] = issue.pc;
		assign issue.grant = grant[g];
	end

	execute_hazard_detect u_hazard (
		.clk(clk),
		.reset_i(reset_i),
		.instruction_i(candidate_instruction),
		.grant_i(grant),
		.hazard_o(hazard)
	);

	// A strand competes only when loaded, enabled and clear of writeback conflicts
	assign arb_request = strand_request & strand_enable_i & ~hazard;

	issue_arbiter u_arbiter (
		.clk(clk),
		.reset_i(reset_i),
		.request_i(arb_request),
		.grant_o(grant)
	);

	// One-hot to index, grant has at most one bit set
	always_comb
	begin
		grant_idx = '0;
		for (int i = 0; i < N; i++)
		begin
			if (grant[i])
				grant_idx = grant_idx | strand_idx_t'(i);
		end
	end

	// Strand number holds its last value through idle cycles
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			ss_instruction_o <= `NOP_INSTRUCTION;
			ss_pc_o <= '0;
			ss_strand_o <= '0;
		end
		else if (|grant)
		begin
			ss_instruction_o <= candidate_instruction[grant_idx];
			ss_pc_o <= candidate_pc[grant_idx];
			ss_strand_o <= grant_idx;
		end
		else
		begin
			ss_instruction_o <= `NOP_INSTRUCTION;
			ss_pc_o <= '0;
		end
	end

endmodule

`default_nettype wire

// File: verif/strand_select_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "strand_config.svh"

module strand_select_tb;
	import strand_pkg::*;

	// Reset plus directed cycles of all tests, with some margin
	localparam int TEST_CYCLES = 150;

	logic clk;
	logic reset_i;
	logic [`STRAND_COUNT-1:0] strand_enable;
	logic [31:0] if_instruction [`STRAND_COUNT];
	logic [`STRAND_COUNT-1:0] if_valid;
	logic [31:0] if_pc [`STRAND_COUNT];
	logic [`STRAND_COUNT-1:0] suspend;
	logic [`STRAND_COUNT-1:0] resume;
	logic [`STRAND_COUNT-1:0] rollback;
	logic [`STRAND_COUNT-1:0] retry;
	logic [`STRAND_COUNT-1:0] fetch_req;
	logic [31:0] ss_instruction;
	logic [31:0] ss_pc;
	strand_idx_t ss_strand;
	// Strand number the output keeps through idle cycles
	strand_idx_t last_strand;

	strand_select_stage dut (
		.clk(clk),
		.reset_i(reset_i),
		.strand_enable_i(strand_enable),
		.if_instruction_i(if_instruction),
		.if_instruction_valid_i(if_valid),
		.if_pc_i(if_pc),
		.suspend_strand_i(suspend),
		.resume_strand_i(resume),
		.rollback_strand_i(rollback),
		.retry_strand_i(retry),
		.ss_instruction_req_o(fetch_req),
		.ss_instruction_o(ss_instruction),
		.ss_pc_o(ss_pc),
		.ss_strand_o(ss_strand)
	);

	always #5 clk = ~clk;

	task automatic check_instruction(input instruction_t expected, input instruction_t actual);
		if (actual !== expected)
		begin
			$display("ERR %0t ss_instruction_o expected %h actual %h", $time, expected, actual);
			$display("FAIL: see errors above");
			$fatal(1, "instruction mismatch");
		end
	endtask

	task automatic check_pc(input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("ERR %0t ss_pc_o expected %h actual %h", $time, expected, actual);
			$display("FAIL: see errors above");
			$fatal(1, "pc mismatch");
		end
	endtask

	task automatic check_strand(input strand_idx_t expected, input strand_idx_t actual);
		if (actual !== expected)
		begin
			$display("ERR %0t ss_strand_o expected %0d actual %0d", $time, expected, actual);
			$display("FAIL: see errors above");
			$fatal(1, "strand mismatch");
		end
	endtask

	task automatic check_req(input logic [3:0] expected, input logic [3:0] actual);
		if (actual !== expected)
		begin
			$display("ERR %0t ss_instruction_req_o expected %b actual %b", $time, expected, actual);
			$display("FAIL: see errors above");
			$fatal(1, "fetch request mismatch");
		end
	endtask

	// Long latency means register format with the top opcode bit set
	function automatic bit long_latency(input logic [31:0] word);
		return word[31] && word[30];
	endfunction

	function automatic instruction_t new_word(input bit long_op);
		instruction_t w;
		w = $urandom;
		if (long_op)
		begin
			w.r.fmt = 1'b1;
			w.r.opcode[5] = 1'b1;
		end
		else if (w.r.fmt)
			w.r.opcode[5] = 1'b0;
		return w;
	endfunction

	function automatic logic [31:0] new_pc();
		return $urandom & 32'hffff_fffc;
	endfunction

	// Advances to the next rising edge and drops all single-cycle pulses
	task automatic next_cycle;
		@(posedge clk);
		if_valid <= '0;
		suspend <= '0;
		resume <= '0;
		rollback <= '0;
		retry <= '0;
	endtask

	task automatic apply_reset;
		next_cycle;
		reset_i <= 1'b1;
		strand_enable <= '1;
		repeat (16) @(posedge clk);
		reset_i <= 1'b0;
		last_strand = '0;
	endtask

	task automatic fetch(input int s, input instruction_t w, input logic [31:0] pc);
		if_instruction[s] <= w;
		if_pc[s] <= pc;
		if_valid[s] <= 1'b1;
	endtask

	task automatic expect_idle;
		@(negedge clk);
		check_instruction(`NOP_INSTRUCTION, ss_instruction);
		check_pc(32'h0, ss_pc);
		check_strand(last_strand, ss_strand);
	endtask

	task automatic expect_issue(input int s, input instruction_t w, input logic [31:0] pc);
		@(negedge clk);
		check_instruction(w, ss_instruction);
		check_pc(pc, ss_pc);
		check_strand(strand_idx_t'(s), ss_strand);
		last_strand = strand_idx_t'(s);
	endtask

	task automatic single_issue;
		instruction_t w;
		logic [31:0] pc;
		w = new_word(1'b0);
		pc = new_pc();
		apply_reset;
		@(negedge clk);
		check_instruction(`NOP_INSTRUCTION, ss_instruction);
		check_pc(32'h0, ss_pc);
		check_strand(2'd0, ss_strand);
		check_req(4'hf, fetch_req);
		next_cycle;
		fetch(2, w, pc);
		expect_idle;
		next_cycle;
		expect_idle;
		check_req(4'b1011, fetch_req);
		next_cycle;
		expect_issue(2, w, pc);
		check_req(4'hf, fetch_req);
		next_cycle;
		expect_idle;
	endtask

	task automatic round_robin;
		instruction_t w [6];
		logic [31:0] pc [6];
		for (int s = 0; s < 6; s++)
		begin
			w[s] = new_word(1'b0);
			pc[s] = new_pc();
		end
		apply_reset;
		next_cycle;
		for (int s = 0; s < 4; s++)
			fetch(s, w[s], pc[s]);
		expect_idle;
		next_cycle;
		expect_idle;
		next_cycle;
		fetch(0, w[4], pc[4]);
		expect_issue(0, w[0], pc[0]);
		next_cycle;
		fetch(1, w[5], pc[5]);
		expect_issue(1, w[1], pc[1]);
		// Reloaded strands wait their turn behind strands 2 and 3
		for (int s = 2; s < 4; s++)
		begin
			next_cycle;
			expect_issue(s, w[s], pc[s]);
		end
		next_cycle;
		expect_issue(0, w[4], pc[4]);
		next_cycle;
		expect_issue(1, w[5], pc[5]);
		next_cycle;
		expect_idle;
	endtask

	task automatic enable_and_suspend;
		instruction_t w [3];
		logic [31:0] pc [3];
		for (int s = 0; s < 3; s++)
		begin
			w[s] = new_word(1'b0);
			pc[s] = new_pc();
		end
		apply_reset;
		next_cycle;
		strand_enable <= 4'b1101;
		suspend <= 4'b1100;
		for (int s = 0; s < 3; s++)
			fetch(s, w[s], pc[s]);
		expect_idle;
		next_cycle;
		expect_idle;
		check_req(4'b0000, fetch_req);
		next_cycle;
		expect_issue(0, w[0], pc[0]);
		check_req(4'b0001, fetch_req);
		repeat (2)
		begin
			next_cycle;
			expect_idle;
		end
		next_cycle;
		strand_enable <= 4'hf;
		expect_idle;
		next_cycle;
		resume <= 4'b1100;
		expect_issue(1, w[1], pc[1]);
		next_cycle;
		expect_idle;
		check_req(4'b1011, fetch_req);
		next_cycle;
		expect_issue(2, w[2], pc[2]);
		check_req(4'hf, fetch_req);
	endtask

	task automatic rollback_and_retry;
		instruction_t w [2];
		logic [31:0] pc [2];
		for (int s = 0; s < 2; s++)
		begin
			w[s] = new_word(1'b0);
			pc[s] = new_pc();
		end
		apply_reset;
		next_cycle;
		strand_enable <= 4'b1101;
		fetch(1, w[0], pc[0]);
		expect_idle;
		next_cycle;
		rollback <= 4'b0010;
		expect_idle;
		check_req(4'b1101, fetch_req);
		next_cycle;
		strand_enable <= 4'hf;
		expect_idle;
		check_req(4'hf, fetch_req);
		next_cycle;
		fetch(1, w[1], pc[1]);
		expect_idle;
		next_cycle;
		expect_idle;
		next_cycle;
		retry <= 4'b0010;
		expect_issue(1, w[1], pc[1]);
		next_cycle;
		expect_idle;
		next_cycle;
		expect_issue(1, w[1], pc[1]);
		next_cycle;
		expect_idle;
	endtask

	task automatic writeback_hazard(input bit second_long);
		instruction_t w [2];
		logic [31:0] pc [2];
		w[0] = new_word(1'b1);
		w[1] = new_word(second_long);
		pc[0] = new_pc();
		pc[1] = new_pc();
		apply_reset;
		next_cycle;
		fetch(0, w[0], pc[0]);
		expect_idle;
		next_cycle;
		expect_idle;
		next_cycle;
		fetch(1, w[1], pc[1]);
		expect_issue(0, w[0], pc[0]);
		next_cycle;
		expect_idle;
		// Strand 1 reaches arbitration in the long word's writeback slot
		if (!long_latency(w[1]))
		begin
			next_cycle;
			expect_idle;
		end
		next_cycle;
		expect_issue(1, w[1], pc[1]);
		next_cycle;
		expect_idle;
	endtask

	initial
	begin
		#(TEST_CYCLES * 10 * 2);
		$display("Watchdog expired before the tests completed");
		$display("FAIL: see errors above");
		$fatal(1, "timeout");
	end

	initial
	begin
		void'($urandom(32'h1051_c8f1));
		clk = 1'b0;
		reset_i = 1'b1;
		strand_enable = '1;
		if_valid = '0;
		suspend = '0;
		resume = '0;
		rollback = '0;
		retry = '0;
		last_strand = '0;
		for (int s = 0; s < `STRAND_COUNT; s++)
		begin
			if_instruction[s] = '0;
			if_pc[s] = '0;
		end
		single_issue;
		round_robin;
		enable_and_suspend;
		rollback_and_retry;
		writeback_hazard(1'b0);
		writeback_hazard(1'b1);
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// File: strand_select_stage.f
+incdir+rtl
rtl/strand_pkg.sv
rtl/strand_issue_if.sv
rtl/strand_fsm.sv
rtl/issue_arbiter.sv
rtl/execute_hazard_detect.sv
rtl/strand_select_stage.sv
verif/strand_select_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --top-module strand_select_tb -f strand_select_stage.f \
	-o strand_select_sim \
	&& ./obj_dir/strand_select_sim \
	|| exit 1
